//--- design/dcache_ctrl.sv
//************************************************************
// cache controller: lookup, eviction, refill and fence flush
// one cpu request or one memory access outstanding at a time
//************************************************************
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  dcache_pkg::cpu_req_t cpu_req_i,
    input  logic                 fence_i,
    output dcache_pkg::cpu_rsp_t cpu_rsp_o,
    output logic                 fence_done_o,
    output dcache_pkg::mem_req_t mem_req_o,
    input  dcache_pkg::mem_rsp_t mem_rsp_i,
    output dcache_pkg::index_t   tag_index_o,
    output dcache_pkg::tag_wr_t  tag_wr_o,
    output logic                 lru_we_o,
    output logic                 lru_way_o,
    input  dcache_pkg::tag_way_t way0_i,
    input  dcache_pkg::tag_way_t way1_i,
    input  logic                 lru_i,
    output dcache_pkg::index_t   data_index_o,
    output dcache_pkg::data_wr_t data_wr_o,
    input  dcache_pkg::word_t    data0_i,
    input  dcache_pkg::word_t    data1_i
);

    dcache_pkg::ctrl_state_t state_q;
    dcache_pkg::ctrl_state_t state_d;
    dcache_pkg::cpu_req_t    req_q;
    // walk counter, {set, way}
    logic [dcache_pkg::INDEX_W:0] cnt_q;
    logic [dcache_pkg::INDEX_W:0] cnt_d;
    logic                         rd_pend_q;
    logic                         rd_pend_d;
    logic                         victim_q;

    logic                   req_start;
    dcache_pkg::tag_t       req_tag;
    dcache_pkg::index_t     req_index;
    dcache_pkg::index_t     rd_index;
    dcache_pkg::index_t     flush_index;
    logic                   flush_way;
    logic                   hit0;
    logic                   hit1;
    logic                   hit_way;
    logic                   victim;
    dcache_pkg::tag_way_t   victim_ent;
    dcache_pkg::tag_way_t   flush_ent;
    dcache_pkg::word_t      victim_data;
    dcache_pkg::word_t      flush_data;
    dcache_pkg::tag_t       wb_tag;

    logic                   mem_go;
    logic                   mem_wr;
    dcache_pkg::addr_t      mem_addr;
    dcache_pkg::word_t      mem_wdata;
    logic                   rsp_go;
    logic                   step;
    logic                   done_go;

    logic                   mem_valid_q;
    logic                   mem_write_q;
    dcache_pkg::addr_t      mem_addr_q;
    dcache_pkg::word_t      mem_wdata_q;
    logic                   rsp_valid_q;
    dcache_pkg::word_t      rsp_data_q;
    logic                   fence_done_q;

    assign req_start = cpu_req_i.rd | cpu_req_i.wr;
    assign req_tag   = req_q.addr[dcache_pkg::ADDR_W-1 -: dcache_pkg::TAG_W];
    assign req_index = req_q.addr[dcache_pkg::OFFSET_W +: dcache_pkg::INDEX_W];

    assign flush_index = cnt_q[dcache_pkg::INDEX_W:1];
    assign flush_way   = cnt_q[0];
    assign flush_ent   = flush_way ? way1_i : way0_i;
    assign flush_data  = flush_way ? data1_i : data0_i;
    assign wb_tag      = mem_addr_q[dcache_pkg::ADDR_W-1 -: dcache_pkg::TAG_W];

    assign hit0    = way0_i.valid && (way0_i.tag == req_tag);
    assign hit1    = way1_i.valid && (way1_i.tag == req_tag);
    assign hit_way = hit1;

    // empty way first, else the lru way
    assign victim      = !way0_i.valid ? 1'b0 : (!way1_i.valid ? 1'b1 : lru_i);
    assign victim_ent  = victim ? way1_i : way0_i;
    assign victim_data = victim ? data1_i : data0_i;

    // arrays sample the incoming request directly while idle
    always_comb begin
        case (state_q)
            dcache_pkg::IDLE: begin
                rd_index = cpu_req_i.addr[dcache_pkg::OFFSET_W +: dcache_pkg::INDEX_W];
            end
            dcache_pkg::FLUSH_RD, dcache_pkg::FLUSH_CHK, dcache_pkg::FLUSH_WB: begin
                rd_index = flush_index;
            end
            default: begin
                rd_index = req_index;
            end
        endcase
    end

    assign tag_index_o  = rd_index;
    assign data_index_o = rd_index;

    always_comb begin
        state_d   = state_q;
        cnt_d     = cnt_q;
        rd_pend_d = 1'b0;
        mem_go    = 1'b0;
        mem_wr    = 1'b0;
        mem_addr  = {req_q.addr[dcache_pkg::ADDR_W-1:dcache_pkg::OFFSET_W],
                     {dcache_pkg::OFFSET_W{1'b0}}};
        mem_wdata = victim_data;
        rsp_go    = 1'b0;
        step      = 1'b0;
        done_go   = 1'b0;
        lru_we_o  = 1'b0;
        lru_way_o = ~hit_way;
        tag_wr_o  = '0;
        data_wr_o = '0;
        case (state_q)
            dcache_pkg::IDLE: begin
                if (req_start) begin
                    state_d = dcache_pkg::LOOKUP;
                end else if (fence_i) begin
                    cnt_d   = '0;
                    state_d = dcache_pkg::FLUSH_RD;
                end
            end
            dcache_pkg::LOOKUP: begin
                if (rd_pend_q) begin
                    // re-read after refill, arrays answer next cycle
                    state_d = dcache_pkg::LOOKUP;
                end else if (hit0 || hit1) begin
                    rsp_go   = 1'b1;
                    lru_we_o = 1'b1;
                    if (req_q.wr) begin
                        tag_wr_o  = '{en: 1'b1, way: hit_way, index: req_index,
                                      tag: req_tag, valid: 1'b1, dirty: 1'b1};
                        data_wr_o = '{en: 1'b1, way: hit_way, index: req_index,
                                      wdata: req_q.wdata, strb: req_q.strb};
                    end
                    state_d = dcache_pkg::IDLE;
                end else begin
                    mem_go = 1'b1;
                    if (victim_ent.valid && victim_ent.dirty) begin
                        mem_wr   = 1'b1;
                        mem_addr = {victim_ent.tag, req_index, {dcache_pkg::OFFSET_W{1'b0}}};
                        state_d  = dcache_pkg::EVICT;
                    end else begin
                        state_d = dcache_pkg::REFILL;
                    end
                end
            end
            dcache_pkg::EVICT: begin
                if (mem_rsp_i.valid) begin
                    mem_go  = 1'b1;
                    state_d = dcache_pkg::REFILL;
                end
            end
            dcache_pkg::REFILL: begin
                if (mem_rsp_i.valid) begin
                    tag_wr_o  = '{en: 1'b1, way: victim_q, index: req_index,
                                  tag: req_tag, valid: 1'b1, dirty: 1'b0};
                    data_wr_o = '{en: 1'b1, way: victim_q, index: req_index,
                                  wdata: mem_rsp_i.rdata, strb: '1};
                    rd_pend_d = 1'b1;
                    state_d   = dcache_pkg::LOOKUP;
                end
            end
            dcache_pkg::FLUSH_RD: begin
                state_d = dcache_pkg::FLUSH_CHK;
            end
            dcache_pkg::FLUSH_CHK: begin
                if (flush_ent.valid && flush_ent.dirty) begin
                    mem_go    = 1'b1;
                    mem_wr    = 1'b1;
                    mem_addr  = {flush_ent.tag, flush_index, {dcache_pkg::OFFSET_W{1'b0}}};
                    mem_wdata = flush_data;
                    state_d   = dcache_pkg::FLUSH_WB;
                end else begin
                    step = 1'b1;
                end
            end
            dcache_pkg::FLUSH_WB: begin
                if (mem_rsp_i.valid) begin
                    // line stays valid, only dirty drops
                    tag_wr_o = '{en: 1'b1, way: flush_way, index: flush_index,
                                 tag: wb_tag, valid: 1'b1, dirty: 1'b0};
                    step     = 1'b1;
                end
            end
            default: begin
                state_d = dcache_pkg::IDLE;
            end
        endcase
        if (step) begin
            if (&cnt_q) begin
                done_go = 1'b1;
                state_d = dcache_pkg::IDLE;
            end else begin
                cnt_d   = cnt_q + 1'b1;
                state_d = dcache_pkg::FLUSH_RD;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q      <= dcache_pkg::IDLE;
            cnt_q        <= '0;
            rd_pend_q    <= 1'b0;
            mem_valid_q  <= 1'b0;
            rsp_valid_q  <= 1'b0;
            fence_done_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            cnt_q        <= cnt_d;
            rd_pend_q    <= rd_pend_d;
            mem_valid_q  <= mem_go;
            rsp_valid_q  <= rsp_go;
            fence_done_q <= done_go;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == dcache_pkg::IDLE && req_start) begin
            req_q <= cpu_req_i;
        end
        if (state_q == dcache_pkg::LOOKUP) begin
            victim_q <= victim;
        end
        if (mem_go) begin
            mem_write_q <= mem_wr;
            mem_addr_q  <= mem_addr;
            mem_wdata_q <= mem_wdata;
        end
        if (rsp_go) begin
            rsp_data_q <= hit_way ? data1_i : data0_i;
        end
    end

    assign cpu_rsp_o    = '{valid: rsp_valid_q, rdata: rsp_data_q};
    assign mem_req_o    = '{valid: mem_valid_q, write: mem_write_q,
                            addr: mem_addr_q, wdata: mem_wdata_q};
    assign fence_done_o = fence_done_q;

endmodule

//--- design/dcache_data_array.sv
//************************************************************
// line storage for both ways, byte-strobe write
//************************************************************
`timescale 1ns/1ps

module dcache_data_array (
    input  logic                 clk,
    input  dcache_pkg::index_t   rd_index_i,
    input  dcache_pkg::data_wr_t wr_i,
    output dcache_pkg::word_t    way0_o,
    output dcache_pkg::word_t    way1_o
);

    dcache_pkg::word_t mem [dcache_pkg::NUM_WAYS][dcache_pkg::NUM_SETS];

    // only strobed bytes of the chosen way change
    always_ff @(posedge clk) begin
        if (wr_i.en) begin
            for (int b = 0; b < dcache_pkg::WORD_W / 8; b++) begin
                if (wr_i.strb[b]) begin
                    mem[wr_i.way][wr_i.index][8*b +: 8] <= wr_i.wdata[8*b +: 8];
                end
            end
        end
    end

    // read returns the contents from before a same-cycle write
    always_ff @(posedge clk) begin
        way0_o <= mem[0][rd_index_i];
        way1_o <= mem[1][rd_index_i];
    end

endmodule

//--- design/dcache_pkg.sv
//************************************************************
// shared widths, types and port structs for the data cache
// every cache file refers to these through dcache_pkg::
//************************************************************
package dcache_pkg;

    localparam int ADDR_W   = 32;
    localparam int WORD_W   = 64;
    localparam int OFFSET_W = 3;
    localparam int INDEX_W  = 6;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;
    localparam int NUM_SETS = 64;
    localparam int NUM_WAYS = 2;

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [WORD_W/8-1:0]   strb_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [INDEX_W-1:0]    index_t;

    // exactly one of rd and wr is high for the request cycle
    typedef struct packed {
        logic  rd;
        logic  wr;
        addr_t addr;
        word_t wdata;
        strb_t strb;
    } cpu_req_t;

    typedef struct packed {
        logic  valid;
        word_t rdata;
    } cpu_rsp_t;

    typedef struct packed {
        logic  valid;
        logic  write;
        addr_t addr;
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic  valid;
        word_t rdata;
    } mem_rsp_t;

    typedef struct packed {
        tag_t tag;
        logic valid;
        logic dirty;
    } tag_way_t;

    typedef struct packed {
        logic   en;
        logic   way;
        index_t index;
        tag_t   tag;
        logic   valid;
        logic   dirty;
    } tag_wr_t;

    typedef struct packed {
        logic   en;
        logic   way;
        index_t index;
        word_t  wdata;
        strb_t  strb;
    } data_wr_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        EVICT,
        REFILL,
        FLUSH_RD,
        FLUSH_CHK,
        FLUSH_WB
    } ctrl_state_t;

endpackage

//--- design/dcache_tag_array.sv
//************************************************************
// tag, valid, dirty and lru storage for both ways
// one write port, both ways read one cycle after the index
//************************************************************
`timescale 1ns/1ps

module dcache_tag_array (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  dcache_pkg::index_t   rd_index_i,
    input  dcache_pkg::tag_wr_t  wr_i,
    input  logic                 lru_we_i,
    input  logic                 lru_way_i,
    output dcache_pkg::tag_way_t way0_o,
    output dcache_pkg::tag_way_t way1_o,
    output logic                 lru_o
);

    dcache_pkg::tag_t tag_mem [dcache_pkg::NUM_WAYS][dcache_pkg::NUM_SETS];

    logic [dcache_pkg::NUM_WAYS-1:0][dcache_pkg::NUM_SETS-1:0] valid_q;
    logic [dcache_pkg::NUM_WAYS-1:0][dcache_pkg::NUM_SETS-1:0] dirty_q;
    // one bit per set, holds the way not used last
    logic [dcache_pkg::NUM_SETS-1:0]                           lru_q;

    dcache_pkg::tag_t                tag0_q;
    dcache_pkg::tag_t                tag1_q;
    logic [dcache_pkg::NUM_WAYS-1:0] valid_rd_q;
    logic [dcache_pkg::NUM_WAYS-1:0] dirty_rd_q;
    logic                            lru_rd_q;

    always_ff @(posedge clk) begin
        if (wr_i.en) begin
            tag_mem[wr_i.way][wr_i.index] <= wr_i.tag;
        end
        tag0_q <= tag_mem[0][rd_index_i];
        tag1_q <= tag_mem[1][rd_index_i];
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q    <= '0;
            dirty_q    <= '0;
            lru_q      <= '0;
            valid_rd_q <= '0;
            dirty_rd_q <= '0;
            lru_rd_q   <= 1'b0;
        end else begin
            if (wr_i.en) begin
                valid_q[wr_i.way][wr_i.index] <= wr_i.valid;
                dirty_q[wr_i.way][wr_i.index] <= wr_i.dirty;
            end
            // lru update goes to the set being looked up
            if (lru_we_i) begin
                lru_q[rd_index_i] <= lru_way_i;
            end
            valid_rd_q <= {valid_q[1][rd_index_i], valid_q[0][rd_index_i]};
            dirty_rd_q <= {dirty_q[1][rd_index_i], dirty_q[0][rd_index_i]};
            lru_rd_q   <= lru_q[rd_index_i];
        end
    end

    assign way0_o = '{tag: tag0_q, valid: valid_rd_q[0], dirty: dirty_rd_q[0]};
    assign way1_o = '{tag: tag1_q, valid: valid_rd_q[1], dirty: dirty_rd_q[1]};
    assign lru_o  = lru_rd_q;

endmodule

//--- design/dcache_top.sv
//************************************************************
// data cache top, controller plus tag and data arrays
//************************************************************
`timescale 1ns/1ps

module dcache_top (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  dcache_pkg::cpu_req_t cpu_req_i,
    output dcache_pkg::cpu_rsp_t cpu_rsp_o,
    input  logic                 fence_i,
    output logic                 fence_done_o,
    output dcache_pkg::mem_req_t mem_req_o,
    input  dcache_pkg::mem_rsp_t mem_rsp_i
);

    dcache_pkg::index_t   tag_index;
    dcache_pkg::tag_wr_t  tag_wr;
    logic                 lru_we;
    logic                 lru_way;
    dcache_pkg::tag_way_t way0;
    dcache_pkg::tag_way_t way1;
    logic                 lru;
    dcache_pkg::index_t   data_index;
    dcache_pkg::data_wr_t data_wr;
    dcache_pkg::word_t    data0;
    dcache_pkg::word_t    data1;

    dcache_ctrl u_ctrl (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .cpu_req_i    (cpu_req_i),
        .fence_i      (fence_i),
        .cpu_rsp_o    (cpu_rsp_o),
        .fence_done_o (fence_done_o),
        .mem_req_o    (mem_req_o),
        .mem_rsp_i    (mem_rsp_i),
        .tag_index_o  (tag_index),
        .tag_wr_o     (tag_wr),
        .lru_we_o     (lru_we),
        .lru_way_o    (lru_way),
        .way0_i       (way0),
        .way1_i       (way1),
        .lru_i        (lru),
        .data_index_o (data_index),
        .data_wr_o    (data_wr),
        .data0_i      (data0),
        .data1_i      (data1)
    );

    dcache_tag_array u_tag (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rd_index_i (tag_index),
        .wr_i       (tag_wr),
        .lru_we_i   (lru_we),
        .lru_way_i  (lru_way),
        .way0_o     (way0),
        .way1_o     (way1),
        .lru_o      (lru)
    );

    dcache_data_array u_data (
        .clk        (clk),
        .rd_index_i (data_index),
        .wr_i       (data_wr),
        .way0_o     (data0),
        .way1_o     (data1)
    );

endmodule

//--- run.sh
#!/bin/sh
# build the cache testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_dcache \
    -f vlog.f -o sim_dcache
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_dcache +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi
exit 0

//--- test/dcache_assert.sv
//************************************************************
// protocol checks on the cache ports, bound to dcache_top
//************************************************************
`timescale 1ns/1ps

module dcache_assert (
    input logic                 clk,
    input logic                 rst_n_i,
    input dcache_pkg::cpu_rsp_t cpu_rsp_i,
    input logic                 fence_done_i,
    input dcache_pkg::mem_req_t mem_req_i,
    input dcache_pkg::mem_rsp_t mem_rsp_i
);

    // failure counts, read by the testbench at the end of the run
    int rsp_fails  = 0;
    int mem_fails  = 0;
    int done_fails = 0;

    logic mem_busy_q;

    // a memory access is open from its request until its response
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem_busy_q <= 1'b0;
        end else if (mem_req_i.valid) begin
            mem_busy_q <= 1'b1;
        end else if (mem_rsp_i.valid) begin
            mem_busy_q <= 1'b0;
        end
    end

    rsp_single: assert property (@(posedge clk) disable iff (!rst_n_i)
        cpu_rsp_i.valid |=> !cpu_rsp_i.valid)
    else begin
        $error("cpu response valid held for two cycles");
        rsp_fails++;
    end

    mem_one_open: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_req_i.valid |-> !mem_busy_q)
    else begin
        $error("memory request issued before the previous response");
        mem_fails++;
    end

    done_apart: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(fence_done_i && cpu_rsp_i.valid))
    else begin
        $error("fence done and cpu response in the same cycle");
        done_fails++;
    end

endmodule

//--- test/tb_dcache.sv
//************************************************************
// data cache testbench with a sparse memory model
// runs five directed tests and reports per test and in total
//************************************************************
`timescale 1ns/1ps

module tb_dcache;

    // three fence walks of 128 entries take most of the run
    localparam int                MAX_CYCLES = 20000;
    localparam int                NUM_DIRTY  = 6;
    localparam logic [31:0]       SEED       = 32'hdf4c_2946;
    localparam dcache_pkg::word_t FILL_KEY   = 64'h3c5a_96e1_0f87_d2b4;

    logic                 clk;
    logic                 rst_n;
    dcache_pkg::cpu_req_t cpu_req;
    dcache_pkg::cpu_rsp_t cpu_rsp;
    logic                 fence;
    logic                 fence_done;
    dcache_pkg::mem_req_t mem_req;
    dcache_pkg::mem_rsp_t mem_rsp = '0;

    dcache_pkg::word_t    mem_q [dcache_pkg::addr_t];
    // data the cpu should see at each line address
    dcache_pkg::word_t    shadow [dcache_pkg::addr_t];
    dcache_pkg::mem_req_t acc_log [$];
    int                   mem_wait        = 0;
    int                   cycle_cnt       = 0;
    int                   errors          = 0;
    int                   checks          = 0;
    int                   tests_run       = 0;
    int                   test_start_errs = 0;
    string                test_name       = "";

    dcache_top uut (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .cpu_req_i    (cpu_req),
        .cpu_rsp_o    (cpu_rsp),
        .fence_i      (fence),
        .fence_done_o (fence_done),
        .mem_req_o    (mem_req),
        .mem_rsp_i    (mem_rsp)
    );

    bind dcache_top dcache_assert u_assert (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .cpu_rsp_i    (cpu_rsp_o),
        .fence_done_i (fence_done_o),
        .mem_req_i    (mem_req_o),
        .mem_rsp_i    (mem_rsp_i)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic dcache_pkg::word_t fill_word(input dcache_pkg::addr_t a);
        return {a, ~a} ^ FILL_KEY;
    endfunction

    function automatic dcache_pkg::word_t expect_word(input dcache_pkg::addr_t a);
        return shadow.exists(a) ? shadow[a] : fill_word(a);
    endfunction

    function automatic dcache_pkg::word_t merge_bytes(input dcache_pkg::word_t old,
                                                      input dcache_pkg::word_t nw,
                                                      input dcache_pkg::strb_t s);
        dcache_pkg::word_t r;
        r = old;
        for (int b = 0; b < 8; b++) begin
            if (s[b]) begin
                r[8*b +: 8] = nw[8*b +: 8];
            end
        end
        return r;
    endfunction

    function automatic dcache_pkg::addr_t line_addr(input dcache_pkg::tag_t t,
                                                    input dcache_pkg::index_t i);
        return {t, i, {dcache_pkg::OFFSET_W{1'b0}}};
    endfunction

    // memory answers each access after 1 to 4 cycles
    always @(negedge clk) begin
        mem_rsp.valid = 1'b0;
        if (mem_wait > 0) begin
            mem_wait--;
            if (mem_wait == 0) begin
                mem_rsp.valid = 1'b1;
            end
        end else if (mem_req.valid) begin
            acc_log.push_back(mem_req);
            if (mem_req.write) begin
                mem_q[mem_req.addr] = mem_req.wdata;
                mem_rsp.rdata = '0;
            end else begin
                mem_rsp.rdata = mem_q.exists(mem_req.addr) ? mem_q[mem_req.addr]
                                                           : fill_word(mem_req.addr);
            end
            mem_wait = 1 + int'($urandom % 4);
        end
    end

    initial begin
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    task automatic begin_test(input string name);
        test_name       = name;
        test_start_errs = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_start_errs) begin
            $display("test %s: passed", test_name);
        end else begin
            $display("test %s: failed with %0d errors", test_name, errors - test_start_errs);
        end
    endtask

    task automatic check_word(input string what, input dcache_pkg::word_t exp,
                              input dcache_pkg::word_t act);
        checks++;
        assert (act === exp) else begin
            $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        checks++;
        assert (act == exp) else begin
            $display("FAIL %s %s: expected %0d, actual %0d", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic cpu_access(input logic wr, input dcache_pkg::addr_t a,
                              input dcache_pkg::word_t d, input dcache_pkg::strb_t s,
                              output dcache_pkg::word_t rdata, output int lat);
        @(negedge clk);
        cpu_req = '{rd: ~wr, wr: wr, addr: a, wdata: d, strb: s};
        @(negedge clk);
        cpu_req = '0;
        lat = 1;
        while (!cpu_rsp.valid) begin
            @(negedge clk);
            lat++;
        end
        rdata = cpu_rsp.rdata;
    endtask

    task automatic load_word(input dcache_pkg::addr_t a, output dcache_pkg::word_t rdata,
                             output int lat);
        cpu_access(1'b0, a, '0, '0, rdata, lat);
    endtask

    task automatic store_word(input dcache_pkg::addr_t a, input dcache_pkg::word_t d,
                              input dcache_pkg::strb_t s);
        dcache_pkg::word_t rdata;
        int                lat;
        shadow[a] = merge_bytes(expect_word(a), d, s);
        cpu_access(1'b1, a, d, s, rdata, lat);
    endtask

    task automatic run_fence();
        @(negedge clk);
        fence = 1'b1;
        @(negedge clk);
        fence = 1'b0;
        while (!fence_done) begin
            @(negedge clk);
        end
    endtask

    task automatic test_reset_quiet();
        int strobes;
        begin_test("reset_quiet");
        strobes = 0;
        repeat (10) begin
            @(negedge clk);
            if (mem_req.valid || cpu_rsp.valid || fence_done) begin
                strobes++;
            end
        end
        check_count("output strobes", 0, strobes);
        check_count("memory accesses", 0, acc_log.size());
        end_test();
    endtask

    task automatic test_read_miss_hit();
        dcache_pkg::addr_t a;
        dcache_pkg::word_t rdata;
        int                lat;
        int                base;
        begin_test("read_miss_hit");
        a    = line_addr(23'h1, 6'd5);
        base = acc_log.size();
        load_word(a, rdata, lat);
        check_word("miss data", expect_word(a), rdata);
        check_count("miss accesses", 1, acc_log.size() - base);
        if (acc_log.size() > base) begin
            check_count("miss write flag", 0, int'(acc_log[base].write));
            check_word("refill address", dcache_pkg::word_t'(a),
                       dcache_pkg::word_t'(acc_log[base].addr));
        end
        base = acc_log.size();
        load_word(a, rdata, lat);
        check_word("hit data", expect_word(a), rdata);
        check_count("hit latency", 2, lat);
        check_count("hit accesses", 0, acc_log.size() - base);
        end_test();
    endtask

    task automatic test_byte_store();
        dcache_pkg::addr_t a;
        dcache_pkg::word_t d;
        dcache_pkg::strb_t s;
        dcache_pkg::word_t exp;
        dcache_pkg::word_t rdata;
        int                lat;
        int                base;
        begin_test("byte_store");
        a    = line_addr(23'h1, 6'd5);
        d    = {$urandom, $urandom};
        s    = dcache_pkg::strb_t'($urandom_range(1, 255));
        exp  = merge_bytes(expect_word(a), d, s);
        base = acc_log.size();
        store_word(a, d, s);
        load_word(a, rdata, lat);
        check_word("merged data", exp, rdata);
        check_count("memory accesses", 0, acc_log.size() - base);
        end_test();
    endtask

    task automatic test_evict_wb();
        dcache_pkg::addr_t a;
        dcache_pkg::addr_t b;
        dcache_pkg::addr_t c;
        dcache_pkg::word_t rdata;
        int                lat;
        int                base;
        begin_test("evict_wb");
        a = line_addr(23'h2, 6'd9);
        b = line_addr(23'h3, 6'd9);
        c = line_addr(23'h4, 6'd9);
        store_word(a, {$urandom, $urandom}, 8'hff);
        store_word(b, {$urandom, $urandom}, dcache_pkg::strb_t'($urandom_range(1, 255)));
        // touching a leaves b as the lru way
        load_word(a, rdata, lat);
        base = acc_log.size();
        load_word(c, rdata, lat);
        check_word("new line data", expect_word(c), rdata);
        check_count("memory accesses", 2, acc_log.size() - base);
        if (acc_log.size() >= base + 2) begin
            check_count("first write flag", 1, int'(acc_log[base].write));
            check_word("writeback address", dcache_pkg::word_t'(b),
                       dcache_pkg::word_t'(acc_log[base].addr));
            check_word("writeback data", expect_word(b), acc_log[base].wdata);
            check_count("second write flag", 0, int'(acc_log[base+1].write));
            check_word("refill address", dcache_pkg::word_t'(c),
                       dcache_pkg::word_t'(acc_log[base+1].addr));
        end
        end_test();
    endtask

    task automatic test_fence_flush();
        dcache_pkg::addr_t addrs [NUM_DIRTY];
        int                base;
        begin_test("fence_flush");
        // start from a cache with no dirty lines
        run_fence();
        for (int i = 0; i < NUM_DIRTY; i++) begin
            addrs[i] = line_addr(dcache_pkg::tag_t'(7 + i), dcache_pkg::index_t'(20 + i));
            store_word(addrs[i], {$urandom, $urandom},
                       dcache_pkg::strb_t'($urandom_range(1, 255)));
        end
        base = acc_log.size();
        run_fence();
        check_count("fence writes", NUM_DIRTY, acc_log.size() - base);
        if (acc_log.size() == base + NUM_DIRTY) begin
            // the walk goes set by set and each set holds one dirty line
            for (int i = 0; i < NUM_DIRTY; i++) begin
                check_count("fence write flag", 1, int'(acc_log[base+i].write));
                check_word("fence address", dcache_pkg::word_t'(addrs[i]),
                           dcache_pkg::word_t'(acc_log[base+i].addr));
                check_word("fence data", expect_word(addrs[i]), acc_log[base+i].wdata);
            end
        end
        base = acc_log.size();
        run_fence();
        check_count("second fence accesses", 0, acc_log.size() - base);
        end_test();
    endtask

    initial begin
        int proto_fails;
        void'($urandom(SEED));
        rst_n   = 1'b0;
        cpu_req = '0;
        fence   = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        test_reset_quiet();
        test_read_miss_hit();
        test_byte_store();
        test_evict_wb();
        test_fence_flush();
        repeat (2) @(negedge clk);
        proto_fails = uut.u_assert.rsp_fails + uut.u_assert.mem_fails
                    + uut.u_assert.done_fails;
        if (proto_fails != 0) begin
            $display("protocol assertions failed %0d times", proto_fails);
            errors += proto_fails;
        end
        $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- vlog.f
design/dcache_pkg.sv
design/dcache_tag_array.sv
design/dcache_data_array.sv
design/dcache_ctrl.sv
design/dcache_top.sv
test/dcache_assert.sv
test/tb_dcache.sv
